// File: Bender.yml
package:
  name: dispatch_stage

sources:
  - logic/dispatch_pkg.sv
  - logic/instr_decoder.sv
  - logic/reg_status_table.sv
  - logic/fu_timer.sv
  - logic/dispatch_stage.sv
  - logic/dispatch_top.sv
  - target: test
    files:
      - dv/dispatch_tb.sv

// File: build.f
logic/dispatch_pkg.sv
logic/instr_decoder.sv
logic/reg_status_table.sv
logic/fu_timer.sv
logic/dispatch_stage.sv
logic/dispatch_top.sv
dv/dispatch_tb.sv

// File: dv/dispatch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_tb;
    import dispatch_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int CLK_PERIOD  = 20;
    // 20 cycles per instruction, far above the longest freeze
    localparam int WATCHDOG_NS = NUM_INSTR * 20 * CLK_PERIOD;

    logic        CLK;
    logic        nRST;
    logic [31:0] instr;
    logic        instr_valid;
    logic        branch_resolved;
    logic        branch_miss;
    dispatch_t   disp;
    logic        freeze;
    wb_t         wb_alu;
    wb_t         wb_ldst;

    // reference model, unit index 0 alu, 1 ldst, 2 branch
    logic        m_busy [NUM_REGS];
    tag_t        m_tag [NUM_REGS];
    logic        m_spec [NUM_REGS];
    int          t_cnt [3];
    regbits_t    t_rd [3];
    logic        t_wr [3];
    logic        t_spec [3];
    logic        m_spec_state;
    logic        m_freeze;
    dispatch_t   m_disp;

    // progress and coverage counts
    int n_done;
    int n_spec_issue;
    int n_freeze;
    int n_miss;
    int n_wb;

    dispatch_top i_dispatch_top (
        .CLK             (CLK),
        .nRST            (nRST),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .disp            (disp),
        .freeze          (freeze),
        .wb_alu          (wb_alu),
        .wb_ldst         (wb_ldst)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic int unit_latency(input int u);
        case (u)
            0:       return LAT_ALU;
            1:       return LAT_LDST;
            default: return LAT_BR;
        endcase
    endfunction

    // instruction format and unit mapping from the opcode table
    function automatic decode_t model_decode(input logic [31:0] w);
        decode_t d;
        d     = '0;
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.op  = op_e'(w[3:0]);
        d.fu  = FU_NONE;
        case (d.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                d.fu        = FU_ALU;
                d.reg_write = 1'b1;
            end
            OP_LD: begin
                d.fu        = FU_LDST;
                d.reg_write = 1'b1;
            end
            OP_ST:         d.fu = FU_LDST;
            OP_BEQ, OP_BNE: d.fu = FU_BR;
            // halt goes out through the alu slot
            OP_HALT: begin
                d.fu   = FU_ALU;
                d.halt = 1'b1;
            end
            OP_NOP:        d.fu = FU_NONE;
            default:       d.op = OP_NOP;
        endcase
        return d;
    endfunction

    // registers 0..3 only, so hazards come often
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        w        = $urandom;
        w[3:0]   = 4'($urandom % 12);
        if (w[3:0] > 4'd9) begin
            w[3:0] = 4'd13;
        end
        w[11:7]  = 5'($urandom % 4);
        w[19:15] = 5'($urandom % 4);
        w[24:20] = 5'($urandom % 4);
        return w;
    endfunction

    task automatic drive_inputs();
        int r;
        // fetch holds the word while frozen
        if (!m_freeze) begin
            instr_valid = ($urandom % 8) != 0;
            instr       = random_instr();
        end
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        if (m_spec_state) begin
            r = $urandom % 16;
            if (r < 2) begin
                branch_resolved = 1'b1;
            end else if (r == 2) begin
                branch_miss = 1'b1;
            end
        end
    endtask

    // check this cycle's outputs, then advance the model by one edge
    task automatic step_model();
        decode_t   d;
        logic      wb_v [2];
        logic      unit_busy;
        logic      hazard;
        logic      issue;
        dispatch_t next_disp;
        int        u;
        d = model_decode(instr);
        check_value("disp", disp, m_disp);
        for (u = 0; u < 2; u++) begin
            wb_v[u] = (t_cnt[u] == 1) && t_wr[u] && !(branch_miss && t_spec[u]);
        end
        check_value("wb_alu.valid", wb_alu.valid, wb_v[0]);
        check_value("wb_ldst.valid", wb_ldst.valid, wb_v[1]);
        if (wb_v[0]) begin
            check_value("wb_alu.rd", wb_alu.rd, t_rd[0]);
        end
        if (wb_v[1]) begin
            check_value("wb_ldst.rd", wb_ldst.rd, t_rd[1]);
        end
        // structural hazard or waw on rd
        unit_busy = (d.fu != FU_NONE) && (t_cnt[int'(d.fu)] != 0);
        hazard    = unit_busy || (d.reg_write && m_busy[d.rd]);
        m_freeze  = instr_valid && hazard;
        check_value("freeze", freeze, m_freeze);
        issue = instr_valid && !hazard && !branch_miss && (d.fu != FU_NONE);
        next_disp = '0;
        if (issue) begin
            next_disp.valid = 1'b1;
            next_disp.fu    = d.fu;
            next_disp.op    = d.op;
            next_disp.rd    = d.rd;
            next_disp.t1    = m_busy[d.rs1] ? m_tag[d.rs1] : TAG_READY;
            next_disp.t2    = m_busy[d.rs2] ? m_tag[d.rs2] : TAG_READY;
            next_disp.spec  = m_spec_state;
            next_disp.halt  = d.halt;
        end
        // status table: retire, claim, then squash
        for (u = 0; u < 2; u++) begin
            if (wb_v[u]) begin
                m_busy[t_rd[u]] = 1'b0;
                n_wb++;
            end
        end
        if (issue && d.reg_write) begin
            if (d.rd != 5'd0) begin
                m_busy[d.rd] = 1'b1;
            end
            m_tag[d.rd]  = (d.fu == FU_LDST) ? TAG_LDST : TAG_ALU;
            m_spec[d.rd] = m_spec_state;
        end
        if (branch_miss) begin
            n_miss++;
            for (u = 0; u < NUM_REGS; u++) begin
                if (m_spec[u]) begin
                    m_busy[u] = 1'b0;
                end
            end
        end
        // occupancy timers
        for (u = 0; u < 3; u++) begin
            if (issue && int'(d.fu) == u) begin
                t_cnt[u]  = unit_latency(u);
                t_rd[u]   = d.rd;
                t_wr[u]   = d.reg_write;
                t_spec[u] = m_spec_state;
            end else if (branch_miss && t_spec[u]) begin
                t_cnt[u] = 0;
            end else if (t_cnt[u] != 0) begin
                t_cnt[u]--;
            end
        end
        if (issue && m_spec_state) begin
            n_spec_issue++;
        end
        if (m_freeze) begin
            n_freeze++;
        end
        // a new branch enters speculation even on a resolve
        if (branch_miss) begin
            m_spec_state = 1'b0;
        end else if (issue && d.fu == FU_BR) begin
            m_spec_state = 1'b1;
        end else if (branch_resolved) begin
            m_spec_state = 1'b0;
        end
        m_disp = next_disp;
        if (instr_valid && !m_freeze) begin
            n_done++;
        end
    endtask

    initial begin
        nRST            = 1'b0;
        instr           = '0;
        instr_valid     = 1'b0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        void'($urandom(32'hbe9f));
        for (int i = 0; i < NUM_REGS; i++) begin
            m_busy[i] = 1'b0;
            m_tag[i]  = TAG_READY;
            m_spec[i] = 1'b0;
        end
        for (int i = 0; i < 3; i++) begin
            t_cnt[i]  = 0;
            t_rd[i]   = '0;
            t_wr[i]   = 1'b0;
            t_spec[i] = 1'b0;
        end
        m_spec_state = 1'b0;
        m_freeze     = 1'b0;
        m_disp       = '0;
        n_done       = 0;
        n_spec_issue = 0;
        n_freeze     = 0;
        n_miss       = 0;
        n_wb         = 0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        // inputs change on falling edges, outputs are checked 1 ns later
        while (n_done < NUM_INSTR) begin
            drive_inputs();
            #1;
            step_model();
            @(negedge CLK);
        end
        if (n_spec_issue == 0 || n_freeze == 0 || n_miss == 0 || n_wb == 0) begin
            $display("coverage hole: spec issues %0d, freezes %0d, misses %0d, wbs %0d",
                     n_spec_issue, n_freeze, n_miss, n_wb);
            $display("Some tests failed");
            $fatal(1, "stimulus missed a behavior");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: logic/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    // scoreboard depth, one entry per scalar register
    localparam int NUM_REGS = 32;

    // unit occupancy in cycles
    localparam int LAT_ALU  = 1;
    localparam int LAT_LDST = 3;
    localparam int LAT_BR   = 2;

    typedef logic [4:0] regbits_t;
    typedef logic [1:0] tag_t;

    // producer tags, 0 means the value is ready
    localparam tag_t TAG_READY = 2'd0;
    localparam tag_t TAG_ALU   = 2'd1;
    localparam tag_t TAG_LDST  = 2'd2;

    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_LDST = 2'd1,
        FU_BR   = 2'd2,
        FU_NONE = 2'd3
    } fu_e;

    // opcode lives in instr[3:0], codes 10..15 are unused
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_LD   = 4'd4,
        OP_ST   = 4'd5,
        OP_BEQ  = 4'd6,
        OP_BNE  = 4'd7,
        OP_HALT = 4'd8,
        OP_NOP  = 4'd9
    } op_e;

    typedef enum logic {
        SPEC_NONE   = 1'b0,
        SPEC_ACTIVE = 1'b1
    } spec_state_e;

    // decoder output
    typedef struct packed {
        fu_e      fu;
        op_e      op;
        regbits_t rd;
        regbits_t rs1;
        regbits_t rs2;
        logic     reg_write;
        logic     halt;
    } decode_t;

    // record handed to the execute side
    typedef struct packed {
        logic     valid;
        fu_e      fu;
        op_e      op;
        regbits_t rd;
        tag_t     t1;
        tag_t     t2;
        logic     spec;
        logic     halt;
    } dispatch_t;

    // timer start
    typedef struct packed {
        logic     en;
        regbits_t rd;
        logic     reg_write;
        logic     spec;
    } issue_t;

    typedef struct packed {
        logic     valid;
        regbits_t rd;
    } wb_t;

endpackage

`default_nettype wire

// File: logic/dispatch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage (
    input  logic                    CLK,
    input  logic                    nRST,
    input  dispatch_pkg::decode_t   dec,
    input  logic                    instr_valid,
    input  logic                    branch_resolved,
    input  logic                    branch_miss,
    input  logic                    busy_alu,
    input  logic                    busy_ldst,
    input  logic                    busy_br,
    input  logic                    rd_busy,
    input  dispatch_pkg::tag_t      tag_rs1,
    input  dispatch_pkg::tag_t      tag_rs2,
    output logic                    wr_en,
    output dispatch_pkg::tag_t      wr_tag,
    output logic                    wr_spec,
    output dispatch_pkg::issue_t    iss_alu,
    output dispatch_pkg::issue_t    iss_ldst,
    output dispatch_pkg::issue_t    iss_br,
    output logic                    freeze,
    output dispatch_pkg::dispatch_t disp
);
    import dispatch_pkg::*;

    spec_state_e spec_state;
    spec_state_e spec_state_n;
    logic        unit_busy;
    logic        waw;
    logic        hazard;
    logic        issue;
    logic        spec_now;
    dispatch_t   disp_n;

    // structural hazard on the target unit
    always_comb begin
        case (dec.fu)
            FU_ALU:  unit_busy = busy_alu;
            FU_LDST: unit_busy = busy_ldst;
            FU_BR:   unit_busy = busy_br;
            default: unit_busy = 1'b0;
        endcase
    end

    // write after write on rd
    assign waw    = dec.reg_write && rd_busy;
    assign hazard = unit_busy || waw;

    // fetch holds the word while frozen
    assign freeze = instr_valid && hazard;

    // nops and unused codes are consumed without issuing
    assign issue    = instr_valid && !hazard && !branch_miss && (dec.fu != FU_NONE);
    assign spec_now = (spec_state == SPEC_ACTIVE);

    // status table write port
    assign wr_en   = issue && dec.reg_write;
    assign wr_tag  = (dec.fu == FU_LDST) ? TAG_LDST : TAG_ALU;
    assign wr_spec = spec_now;

    // one start per unit, only the target one is enabled
    assign iss_alu  = '{en: issue && dec.fu == FU_ALU, rd: dec.rd,
                        reg_write: dec.reg_write, spec: spec_now};
    assign iss_ldst = '{en: issue && dec.fu == FU_LDST, rd: dec.rd,
                        reg_write: dec.reg_write, spec: spec_now};
    assign iss_br   = '{en: issue && dec.fu == FU_BR, rd: dec.rd,
                        reg_write: dec.reg_write, spec: spec_now};

    // speculation fsm
    always_comb begin
        spec_state_n = spec_state;
        if (branch_miss) begin
            spec_state_n = SPEC_NONE;
        end else if (issue && dec.fu == FU_BR) begin
            // a fresh branch outranks a resolve of the older one
            spec_state_n = SPEC_ACTIVE;
        end else if (branch_resolved) begin
            spec_state_n = SPEC_NONE;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec_state <= SPEC_NONE;
        end else begin
            spec_state <= spec_state_n;
        end
    end

    // bubble unless something issues
    always_comb begin
        disp_n = '0;
        if (issue) begin
            disp_n.valid = 1'b1;
            disp_n.fu    = dec.fu;
            disp_n.op    = dec.op;
            disp_n.rd    = dec.rd;
            // operand producers at issue time
            disp_n.t1    = tag_rs1;
            disp_n.t2    = tag_rs2;
            disp_n.spec  = spec_now;
            disp_n.halt  = dec.halt;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            disp <= '0;
        end else begin
            disp <= disp_n;
        end
    end

    // fetch keeps a frozen word in place until it goes through
    assert property (@(posedge CLK) disable iff (!nRST)
        freeze |=> instr_valid && $stable(dec))
        else $error("dispatch: fetch changed the word while frozen");

endmodule

`default_nettype wire

// File: logic/dispatch_top.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic [31:0]             instr,
    input  logic                    instr_valid,
    input  logic                    branch_resolved,
    input  logic                    branch_miss,
    output dispatch_pkg::dispatch_t disp,
    output logic                    freeze,
    output dispatch_pkg::wb_t       wb_alu,
    output dispatch_pkg::wb_t       wb_ldst
);
    import dispatch_pkg::*;

    decode_t dec;
    logic    wr_en;
    tag_t    wr_tag;
    logic    wr_spec;
    logic    rd_busy;
    tag_t    tag_rs1;
    tag_t    tag_rs2;
    issue_t  iss_alu;
    issue_t  iss_ldst;
    issue_t  iss_br;
    logic    busy_alu;
    logic    busy_ldst;
    logic    busy_br;

    instr_decoder i_instr_decoder (
        .instr (instr),
        .dec   (dec)
    );

    dispatch_stage i_dispatch_stage (
        .CLK             (CLK),
        .nRST            (nRST),
        .dec             (dec),
        .instr_valid     (instr_valid),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .busy_alu        (busy_alu),
        .busy_ldst       (busy_ldst),
        .busy_br         (busy_br),
        .rd_busy         (rd_busy),
        .tag_rs1         (tag_rs1),
        .tag_rs2         (tag_rs2),
        .wr_en           (wr_en),
        .wr_tag          (wr_tag),
        .wr_spec         (wr_spec),
        .iss_alu         (iss_alu),
        .iss_ldst        (iss_ldst),
        .iss_br          (iss_br),
        .freeze          (freeze),
        .disp            (disp)
    );

    // write index and lookups come from the decoded fields
    reg_status_table i_reg_status_table (
        .CLK     (CLK),
        .nRST    (nRST),
        .wr_en   (wr_en),
        .wr_sel  (dec.rd),
        .wr_tag  (wr_tag),
        .wr_spec (wr_spec),
        .wb_alu  (wb_alu),
        .wb_ldst (wb_ldst),
        .flush   (branch_miss),
        .rd_sel  (dec.rd),
        .rs1_sel (dec.rs1),
        .rs2_sel (dec.rs2),
        .rd_busy (rd_busy),
        .tag_rs1 (tag_rs1),
        .tag_rs2 (tag_rs2)
    );

    fu_timer #(.LATENCY(LAT_ALU)) i_timer_alu (
        .CLK   (CLK),
        .nRST  (nRST),
        .start (iss_alu),
        .flush (branch_miss),
        .busy  (busy_alu),
        .wb    (wb_alu)
    );

    fu_timer #(.LATENCY(LAT_LDST)) i_timer_ldst (
        .CLK   (CLK),
        .nRST  (nRST),
        .start (iss_ldst),
        .flush (branch_miss),
        .busy  (busy_ldst),
        .wb    (wb_ldst)
    );

    // branches never write a register
    fu_timer #(.LATENCY(LAT_BR)) i_timer_br (
        .CLK   (CLK),
        .nRST  (nRST),
        .start (iss_br),
        .flush (branch_miss),
        .busy  (busy_br),
        .wb    ()
    );

endmodule

`default_nettype wire

// File: logic/fu_timer.sv
`timescale 1ns/1ns
`default_nettype none

module fu_timer #(
    parameter int LATENCY = 1
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dispatch_pkg::issue_t start,
    input  logic                 flush,
    output logic                 busy,
    output dispatch_pkg::wb_t    wb
);
    import dispatch_pkg::*;

    typedef logic [$clog2(LATENCY+1)-1:0] cnt_t;

    cnt_t     count;
    regbits_t rd_q;
    logic     reg_write_q;
    logic     spec_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count       <= '0;
            rd_q        <= '0;
            reg_write_q <= 1'b0;
            spec_q      <= 1'b0;
        end else if (start.en) begin
            // occupy the unit for the full latency
            count       <= cnt_t'(LATENCY);
            rd_q        <= start.rd;
            reg_write_q <= start.reg_write;
            spec_q      <= start.spec;
        end else if (flush && spec_q) begin
            // wrong path, drop the occupation
            count <= '0;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // last cycle of occupation, squashed op never writes back
    assign wb.valid = (count == cnt_t'(1)) && reg_write_q && !(flush && spec_q);
    assign wb.rd    = rd_q;

    // structural hazard check upstream keeps starts apart
    assert property (@(posedge CLK) disable iff (!nRST) start.en |-> !busy)
        else $error("fu_timer: start while busy");

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  logic [31:0]           instr,
    output dispatch_pkg::decode_t dec
);
    import dispatch_pkg::*;

    op_e raw_op;

    // opcode field, may hold an unused code
    assign raw_op = op_e'(instr[3:0]);

    always_comb begin
        // register fields come straight from the word
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.op        = raw_op;
        dec.fu        = FU_NONE;
        dec.reg_write = 1'b0;
        dec.halt      = 1'b0;
        case (raw_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                dec.fu        = FU_ALU;
                dec.reg_write = 1'b1;
            end
            OP_LD: begin
                dec.fu        = FU_LDST;
                dec.reg_write = 1'b1;
            end
            // store has no destination
            OP_ST: begin
                dec.fu = FU_LDST;
            end
            OP_BEQ, OP_BNE: begin
                dec.fu = FU_BR;
            end
            // halt rides the alu slot so it reaches disp
            OP_HALT: begin
                dec.fu   = FU_ALU;
                dec.halt = 1'b1;
            end
            OP_NOP: begin
                dec.fu = FU_NONE;
            end
            // unused codes fall back to a nop
            default: begin
                dec.op = OP_NOP;
                dec.fu = FU_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_status_table.sv
`timescale 1ns/1ns
`default_nettype none

module reg_status_table (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   wr_en,
    input  dispatch_pkg::regbits_t wr_sel,
    input  dispatch_pkg::tag_t     wr_tag,
    input  logic                   wr_spec,
    input  dispatch_pkg::wb_t      wb_alu,
    input  dispatch_pkg::wb_t      wb_ldst,
    input  logic                   flush,
    input  dispatch_pkg::regbits_t rd_sel,
    input  dispatch_pkg::regbits_t rs1_sel,
    input  dispatch_pkg::regbits_t rs2_sel,
    output logic                   rd_busy,
    output dispatch_pkg::tag_t     tag_rs1,
    output dispatch_pkg::tag_t     tag_rs2
);
    import dispatch_pkg::*;

    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] busy_n;
    logic [NUM_REGS-1:0] spec;
    tag_t                tag [NUM_REGS];

    always_comb begin
        busy_n = busy;
        // writebacks retire their producers
        if (wb_alu.valid) begin
            busy_n[wb_alu.rd] = 1'b0;
        end
        if (wb_ldst.valid) begin
            busy_n[wb_ldst.rd] = 1'b0;
        end
        // r0 is hardwired, never tracked
        if (wr_en && wr_sel != '0) begin
            busy_n[wr_sel] = 1'b1;
        end
        // squash wins over everything speculative
        if (flush) begin
            busy_n = busy_n & ~spec;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
        end else begin
            busy <= busy_n;
        end
    end

    // producer tag and spec mark, only meaningful while busy
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tag[wr_sel]  <= wr_tag;
            spec[wr_sel] <= wr_spec;
        end
    end

    assign rd_busy = busy[rd_sel];
    assign tag_rs1 = busy[rs1_sel] ? tag[rs1_sel] : TAG_READY;
    assign tag_rs2 = busy[rs2_sel] ? tag[rs2_sel] : TAG_READY;

    // stage must hold off a waw before writing the entry
    assert property (@(posedge CLK) disable iff (!nRST) wr_en |-> !busy[wr_sel])
        else $error("status table: write to busy register %0d", wr_sel);

endmodule

`default_nettype wire
